//--- flist.f
rtl/core_types_pkg.sv
rtl/q_fast_ready.sv
rtl/oc_wb_if.sv
rtl/alu.sv
rtl/alu_operand_collect.sv
rtl/alu_wb_stage.sv
rtl/alu_reg_pipeline.sv
verif/alu_reg_pipeline_chk.sv
verif/alu_reg_pipeline_tb.sv

//--- Bender.yml
package:
  name: alu_reg_pipeline

sources:
  - files:
      - rtl/core_types_pkg.sv
      - rtl/q_fast_ready.sv
      - rtl/oc_wb_if.sv
      - rtl/alu.sv
      - rtl/alu_operand_collect.sv
      - rtl/alu_wb_stage.sv
      - rtl/alu_reg_pipeline.sv
  - target: test
    files:
      - verif/alu_reg_pipeline_chk.sv
      - verif/alu_reg_pipeline_tb.sv

//--- verif/alu_reg_pipeline_tb.sv
`default_nettype none

module alu_reg_pipeline_tb;
    import core_types_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_REG_OPS = 30;
    localparam int N_MIX_OPS = 120;
    localparam int N_OPS = N_REG_OPS + N_MIX_OPS + 10;
    localparam int FULL_DEPTH = IS_OC_BUFFER_SIZE + 1;
    localparam int DRAIN_CYCLES = 200;

    logic       CLK;
    logic       nRST;
    logic       issue_valid;
    alu_op_t    issue_op;
    logic       issue_A_forward;
    logic       issue_A_is_zero;
    bank_t      issue_A_bank;
    logic       issue_B_forward;
    logic       issue_B_is_zero;
    bank_t      issue_B_bank;
    pr_tag_t    issue_dest_PR;
    rob_index_t issue_ROB_index;
    logic       issue_ready;
    logic       A_reg_read_resp_valid;
    word_t      A_reg_read_resp_data;
    logic       B_reg_read_resp_valid;
    word_t      B_reg_read_resp_data;
    word_t [PRF_BANK_COUNT-1:0] forward_data_by_bank;
    logic       WB_valid;
    word_t      WB_data;
    pr_tag_t    WB_PR;
    rob_index_t WB_ROB_index;
    logic       WB_ready;

    logic [31:0] seed = 32'hc8cb_033f;
    alu_op_t op_list [10] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                              ALU_SRL, ALU_OR, ALU_AND, ALU_SUB, ALU_SRA};

    // expected results in issue order
    word_t      exp_data_q[$];
    pr_tag_t    exp_pr_q[$];
    rob_index_t exp_rob_q[$];

    // pending register read responses and the cycle they may start
    word_t a_resp_q[$];
    int    a_resp_cyc_q[$];
    word_t b_resp_q[$];
    int    b_resp_cyc_q[$];

    // next micro-op, held until accepted
    alu_op_t    cand_op;
    logic       cand_a_fwd;
    logic       cand_a_zero;
    bank_t      cand_a_bank;
    word_t      cand_a_val;
    logic       cand_b_fwd;
    logic       cand_b_zero;
    bank_t      cand_b_bank;
    word_t      cand_b_val;
    pr_tag_t    cand_pr;
    rob_index_t cand_rob;

    logic issue_fire;
    logic wb_fire;
    logic issuing;
    int   src_mode;
    int   wb_mode;
    int   cycle;
    int   issued;
    int   written;

    alu_reg_pipeline dut (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // -------------------------------------------------------------------
    // helpers

    function automatic logic [31:0] xorshift32();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = xorshift32();
        return r[0];
    endfunction

    // reference ALU, arithmetic shift built from a logical one
    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        word_t res;
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a + ~b + 32'd1;
            ALU_SLL:  res = a << b[4:0];
            ALU_SRL:  res = a >> b[4:0];
            ALU_SRA:  res = (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}});
            ALU_SLT:  res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: res = {31'b0, a < b};
            ALU_XOR:  res = a ^ b;
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            default:  res = '0;
        endcase
        return res;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic verify_tag(input string name, input pr_tag_t exp, input pr_tag_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic match_rob_index(input string name, input rob_index_t exp,
                                   input rob_index_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic expect_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    // -------------------------------------------------------------------
    // stimulus and model

    task automatic make_candidate();
        int src_a;
        int src_b;
        if (src_mode == 0) begin
            cand_op = op_list[issued % 10];
            src_a = 0;
            src_b = 0;
        end else begin
            cand_op = op_list[xorshift32() % 32'd10];
            src_a = int'(xorshift32() % 32'd3);
            src_b = int'(xorshift32() % 32'd3);
        end
        // 0 register, 1 forward, 2 zero
        cand_a_fwd = (src_a == 1);
        cand_a_zero = (src_a == 2);
        cand_b_fwd = (src_b == 1);
        cand_b_zero = (src_b == 2);
        cand_a_bank = bank_t'(xorshift32());
        cand_b_bank = bank_t'(xorshift32());
        cand_a_val = cand_a_zero ? '0 : xorshift32();
        cand_b_val = cand_b_zero ? '0 : xorshift32();
        // one bank carries one word
        if (cand_a_fwd && cand_b_fwd && cand_a_bank == cand_b_bank) begin
            cand_b_val = cand_a_val;
        end
        cand_pr = pr_tag_t'(xorshift32());
        cand_rob = rob_index_t'(issued);
    endtask

    task automatic drive_inputs();
        cycle++;
        for (int i = 0; i < PRF_BANK_COUNT; i++) begin
            forward_data_by_bank[i] = xorshift32();
        end
        if (issue_fire) begin
            exp_data_q.push_back(alu_model(cand_op, cand_a_val, cand_b_val));
            exp_pr_q.push_back(cand_pr);
            exp_rob_q.push_back(cand_rob);
            if (!cand_a_fwd && !cand_a_zero) begin
                a_resp_q.push_back(cand_a_val);
                a_resp_cyc_q.push_back(cycle);
            end
            if (!cand_b_fwd && !cand_b_zero) begin
                b_resp_q.push_back(cand_b_val);
                b_resp_cyc_q.push_back(cycle);
            end
            // forwarded words in the cycle after issue
            if (cand_a_fwd) begin
                forward_data_by_bank[cand_a_bank] = cand_a_val;
            end
            if (cand_b_fwd) begin
                forward_data_by_bank[cand_b_bank] = cand_b_val;
            end
            issued++;
            make_candidate();
        end
        issue_valid = issuing && (src_mode == 0 || coin());
        issue_op = cand_op;
        issue_A_forward = cand_a_fwd;
        issue_A_is_zero = cand_a_zero;
        issue_A_bank = cand_a_bank;
        issue_B_forward = cand_b_fwd;
        issue_B_is_zero = cand_b_zero;
        issue_B_bank = cand_b_bank;
        issue_dest_PR = cand_pr;
        issue_ROB_index = cand_rob;

        // register responses in issue order, random delay
        A_reg_read_resp_valid = 1'b0;
        A_reg_read_resp_data = xorshift32();
        if (a_resp_q.size() != 0 && a_resp_cyc_q[0] <= cycle && coin()) begin
            A_reg_read_resp_valid = 1'b1;
            A_reg_read_resp_data = a_resp_q.pop_front();
            void'(a_resp_cyc_q.pop_front());
        end
        B_reg_read_resp_valid = 1'b0;
        B_reg_read_resp_data = xorshift32();
        if (b_resp_q.size() != 0 && b_resp_cyc_q[0] <= cycle && coin()) begin
            B_reg_read_resp_valid = 1'b1;
            B_reg_read_resp_data = b_resp_q.pop_front();
            void'(b_resp_cyc_q.pop_front());
        end

        case (wb_mode)
            0: WB_ready = 1'b1;
            1: WB_ready = coin();
            default: WB_ready = 1'b0;
        endcase
    endtask

    // mid-cycle, all outputs settled
    task automatic sample_outputs();
        issue_fire = issue_valid & issue_ready;
        wb_fire = WB_valid & WB_ready;
        if (WB_valid) begin
            if (exp_data_q.size() == 0) begin
                abort_run("writeback seen with no micro-op outstanding");
            end else begin
                check_word("WB_data", exp_data_q[0], WB_data);
                verify_tag("WB_PR", exp_pr_q[0], WB_PR);
                match_rob_index("WB_ROB_index", exp_rob_q[0], WB_ROB_index);
            end
        end
        if (wb_fire) begin
            void'(exp_data_q.pop_front());
            void'(exp_pr_q.pop_front());
            void'(exp_rob_q.pop_front());
            written++;
        end
    endtask

    task automatic run_cycle();
        @(posedge CLK);
        #5;
        drive_inputs();
        @(negedge CLK);
        sample_outputs();
    endtask

    // -------------------------------------------------------------------
    // sequence

    initial begin
        int waited;
        issue_valid = 1'b0;
        issue_op = ALU_ADD;
        issue_A_forward = 1'b0;
        issue_A_is_zero = 1'b0;
        issue_A_bank = '0;
        issue_B_forward = 1'b0;
        issue_B_is_zero = 1'b0;
        issue_B_bank = '0;
        issue_dest_PR = '0;
        issue_ROB_index = '0;
        A_reg_read_resp_valid = 1'b0;
        A_reg_read_resp_data = '0;
        B_reg_read_resp_valid = 1'b0;
        B_reg_read_resp_data = '0;
        forward_data_by_bank = '0;
        WB_ready = 1'b0;
        issuing = 1'b0;
        src_mode = 0;
        wb_mode = 0;
        cycle = 0;
        issued = 0;
        written = 0;

        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        #5;
        nRST = 1'b1;
        @(negedge CLK);
        expect_flag("WB_valid", 1'b0, WB_valid);
        expect_flag("issue_ready", 1'b1, issue_ready);
        sample_outputs();
        make_candidate();

        // every op in turn, register operands only
        issuing = 1'b1;
        while (issued < N_REG_OPS) begin
            run_cycle();
        end

        // mixed sources under random back-pressure
        src_mode = 1;
        wb_mode = 1;
        while (issued < N_REG_OPS + N_MIX_OPS) begin
            run_cycle();
        end

        // writeback blocked until queue and WB register fill
        wb_mode = 2;
        run_cycle();
        waited = 0;
        while (!(WB_valid && !issue_ready)) begin
            if (waited == 30) begin
                abort_run("issue_ready did not fall with WB_ready held low");
            end
            run_cycle();
            waited++;
        end
        if (exp_data_q.size() != FULL_DEPTH) begin
            abort_run($sformatf("%0d micro-ops held while full, %0d expected",
                                exp_data_q.size(), FULL_DEPTH));
        end
        repeat (6) begin
            run_cycle();
            expect_flag("issue_ready", 1'b0, issue_ready);
            expect_flag("WB_valid", 1'b1, WB_valid);
        end

        // drain
        issuing = 1'b0;
        wb_mode = 1;
        waited = 0;
        while ((issue_fire || exp_data_q.size() != 0 || a_resp_q.size() != 0
                || b_resp_q.size() != 0) && waited < DRAIN_CYCLES) begin
            run_cycle();
            waited++;
        end
        repeat (4) run_cycle();

        if (written != issued) begin
            abort_run($sformatf("%0d micro-ops issued but %0d written back", issued, written));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(40 * N_OPS * CLK_PERIOD);
        abort_run("timeout, the pipeline stalled");
    end

endmodule

`default_nettype wire

//--- verif/alu_reg_pipeline_chk.sv
`default_nettype none

module alu_reg_pipeline_chk (
    input logic                       CLK,
    input logic                       nRST,
    input logic                       WB_valid,
    input core_types_pkg::word_t      WB_data,
    input core_types_pkg::pr_tag_t    WB_PR,
    input core_types_pkg::rob_index_t WB_ROB_index,
    input logic                       WB_ready,
    input logic                       a_reg_enq,
    input logic                       a_reg_room,
    input logic                       b_reg_enq,
    input logic                       b_reg_room,
    input logic                       a_fwd_enq,
    input logic                       a_fwd_room,
    input logic                       b_fwd_enq,
    input logic                       b_fwd_room
);

    // -------------------------------------------------------------------
    // writeback handshake

    assert property (@(posedge CLK) disable iff (!nRST)
        WB_valid && !WB_ready |=> WB_valid && $stable(WB_data) && $stable(WB_PR)
            && $stable(WB_ROB_index))
        else $error("writeback outputs changed during a stall");

    assert property (@(posedge CLK) !nRST |-> !WB_valid)
        else $error("WB_valid high during reset");

    // -------------------------------------------------------------------
    // data buffers never overflow

    assert property (@(posedge CLK) disable iff (!nRST) a_reg_enq |-> a_reg_room)
        else $error("A register buffer written while full");

    assert property (@(posedge CLK) disable iff (!nRST) b_reg_enq |-> b_reg_room)
        else $error("B register buffer written while full");

    assert property (@(posedge CLK) disable iff (!nRST) a_fwd_enq |-> a_fwd_room)
        else $error("A forward buffer written while full");

    assert property (@(posedge CLK) disable iff (!nRST) b_fwd_enq |-> b_fwd_room)
        else $error("B forward buffer written while full");

endmodule

bind alu_reg_pipeline alu_reg_pipeline_chk u_chk (
    .CLK         (CLK),
    .nRST        (nRST),
    .WB_valid    (WB_valid),
    .WB_data     (WB_data),
    .WB_PR       (WB_PR),
    .WB_ROB_index(WB_ROB_index),
    .WB_ready    (WB_ready),
    .a_reg_enq   (u_collect.a_reg_buf.enq_valid),
    .a_reg_room  (u_collect.a_reg_buf.enq_ready),
    .b_reg_enq   (u_collect.b_reg_buf.enq_valid),
    .b_reg_room  (u_collect.b_reg_buf.enq_ready),
    .a_fwd_enq   (u_collect.a_fwd_buf.enq_valid),
    .a_fwd_room  (u_collect.a_fwd_buf.enq_ready),
    .b_fwd_enq   (u_collect.b_fwd_buf.enq_valid),
    .b_fwd_room  (u_collect.b_fwd_buf.enq_ready)
);

`default_nettype wire

//--- rtl/alu_reg_pipeline.sv
`default_nettype none

module alu_reg_pipeline (
    input  logic                          CLK,
    input  logic                          nRST,

    // issue from the IQ
    input  logic                          issue_valid,
    input  core_types_pkg::alu_op_t       issue_op,
    input  logic                          issue_A_forward,
    input  logic                          issue_A_is_zero,
    input  core_types_pkg::bank_t         issue_A_bank,
    input  logic                          issue_B_forward,
    input  logic                          issue_B_is_zero,
    input  core_types_pkg::bank_t         issue_B_bank,
    input  core_types_pkg::pr_tag_t       issue_dest_PR,
    input  core_types_pkg::rob_index_t    issue_ROB_index,
    output logic                          issue_ready,

    // PRF read responses
    input  logic                          A_reg_read_resp_valid,
    input  core_types_pkg::word_t         A_reg_read_resp_data,
    input  logic                          B_reg_read_resp_valid,
    input  core_types_pkg::word_t         B_reg_read_resp_data,

    input  core_types_pkg::word_t [core_types_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank,

    // writeback to the PRF
    output logic                          WB_valid,
    output core_types_pkg::word_t         WB_data,
    output core_types_pkg::pr_tag_t       WB_PR,
    output core_types_pkg::rob_index_t    WB_ROB_index,
    input  logic                          WB_ready
);

    oc_wb_if oc_wb ();

    alu_operand_collect u_collect (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .issue_valid          (issue_valid),
        .issue_op             (issue_op),
        .issue_A_forward      (issue_A_forward),
        .issue_A_is_zero      (issue_A_is_zero),
        .issue_A_bank         (issue_A_bank),
        .issue_B_forward      (issue_B_forward),
        .issue_B_is_zero      (issue_B_is_zero),
        .issue_B_bank         (issue_B_bank),
        .issue_dest_PR        (issue_dest_PR),
        .issue_ROB_index      (issue_ROB_index),
        .issue_ready          (issue_ready),
        .A_reg_read_resp_valid(A_reg_read_resp_valid),
        .A_reg_read_resp_data (A_reg_read_resp_data),
        .B_reg_read_resp_valid(B_reg_read_resp_valid),
        .B_reg_read_resp_data (B_reg_read_resp_data),
        .forward_data_by_bank (forward_data_by_bank),
        .oc                   (oc_wb.collect)
    );

    alu_wb_stage u_wb (
        .CLK         (CLK),
        .nRST        (nRST),
        .oc          (oc_wb.wb),
        .WB_valid    (WB_valid),
        .WB_data     (WB_data),
        .WB_PR       (WB_PR),
        .WB_ROB_index(WB_ROB_index),
        .WB_ready    (WB_ready)
    );

endmodule

`default_nettype wire

//--- rtl/alu_wb_stage.sv
`default_nettype none

module alu_wb_stage (
    input  logic                        CLK,
    input  logic                        nRST,

    oc_wb_if.wb                         oc,

    output logic                        WB_valid,
    output core_types_pkg::word_t       WB_data,
    output core_types_pkg::pr_tag_t     WB_PR,
    output core_types_pkg::rob_index_t  WB_ROB_index,
    input  logic                        WB_ready
);
    import core_types_pkg::*;

    alu_uop_t wb_uop;
    logic     stall;
    logic     wb_done;
    word_t    wb_A;
    word_t    wb_B;

    // -------------------------------------------------------------------
    // control

    assign stall = WB_valid & ~WB_ready;
    assign wb_done = WB_valid & WB_ready;
    assign oc.advance = ~stall;

    // -------------------------------------------------------------------
    // WB register

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            WB_valid <= 1'b0;
        end else if (~stall) begin
            WB_valid <= oc.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall) begin
            wb_uop <= oc.uop;
        end
    end

    assign WB_PR = wb_uop.dest_PR;
    assign WB_ROB_index = wb_uop.ROB_index;

    // -------------------------------------------------------------------
    // operand gather, zero when neither source

    always_comb begin
        wb_A = '0;
        if (wb_uop.A_is_reg) begin
            wb_A = oc.A_reg_data;
        end else if (wb_uop.A_forward) begin
            wb_A = oc.A_fwd_data;
        end

        wb_B = '0;
        if (wb_uop.B_is_reg) begin
            wb_B = oc.B_reg_data;
        end else if (wb_uop.B_forward) begin
            wb_B = oc.B_fwd_data;
        end
    end

    // release buffer heads once the result is taken
    assign oc.A_reg_pop = wb_done & wb_uop.A_is_reg;
    assign oc.A_fwd_pop = wb_done & wb_uop.A_forward;
    assign oc.B_reg_pop = wb_done & wb_uop.B_is_reg;
    assign oc.B_fwd_pop = wb_done & wb_uop.B_forward;

    alu u_alu (
        .op (wb_uop.op),
        .A  (wb_A),
        .B  (wb_B),
        .out(WB_data)
    );

endmodule

`default_nettype wire

//--- rtl/alu_operand_collect.sv
`default_nettype none

module alu_operand_collect (
    input  logic                          CLK,
    input  logic                          nRST,

    // issue
    input  logic                          issue_valid,
    input  core_types_pkg::alu_op_t       issue_op,
    input  logic                          issue_A_forward,
    input  logic                          issue_A_is_zero,
    input  core_types_pkg::bank_t         issue_A_bank,
    input  logic                          issue_B_forward,
    input  logic                          issue_B_is_zero,
    input  core_types_pkg::bank_t         issue_B_bank,
    input  core_types_pkg::pr_tag_t       issue_dest_PR,
    input  core_types_pkg::rob_index_t    issue_ROB_index,
    output logic                          issue_ready,

    // register read responses
    input  logic                          A_reg_read_resp_valid,
    input  core_types_pkg::word_t         A_reg_read_resp_data,
    input  logic                          B_reg_read_resp_valid,
    input  core_types_pkg::word_t         B_reg_read_resp_data,

    input  core_types_pkg::word_t [core_types_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank,

    oc_wb_if.collect                      oc
);
    import core_types_pkg::*;

    alu_uop_t issue_uop;
    alu_uop_t head_uop;
    logic     head_valid;
    logic     head_fire;
    logic     issue_fire;

    logic     a_present;
    logic     b_present;
    logic [RR_CREDIT_W-1:0] a_reg_credit;
    logic [RR_CREDIT_W-1:0] b_reg_credit;

    logic     a_reg_deq_valid;
    word_t    a_reg_deq_data;
    logic     b_reg_deq_valid;
    word_t    b_reg_deq_data;

    logic     a_fwd_enq;
    logic     b_fwd_enq;
    bank_t    a_fwd_bank;
    bank_t    b_fwd_bank;

    // -------------------------------------------------------------------
    // issue decode and IS->OC queue

    assign issue_fire = issue_valid & issue_ready;

    // register read when neither forwarded nor zero
    always_comb begin
        issue_uop.op = issue_op;
        issue_uop.A_forward = issue_A_forward;
        issue_uop.A_is_reg = ~(issue_A_forward | issue_A_is_zero);
        issue_uop.B_forward = issue_B_forward;
        issue_uop.B_is_reg = ~(issue_B_forward | issue_B_is_zero);
        issue_uop.dest_PR = issue_dest_PR;
        issue_uop.ROB_index = issue_ROB_index;
    end

    q_fast_ready #(
        .payload_t  (alu_uop_t),
        .NUM_ENTRIES(IS_OC_BUFFER_SIZE)
    ) uop_q (
        .CLK      (CLK),
        .nRST     (nRST),
        .enq_valid(issue_valid),
        .enq_data (issue_uop),
        .enq_ready(issue_ready),
        .deq_valid(head_valid),
        .deq_data (head_uop),
        .deq_ready(head_fire)
    );

    // -------------------------------------------------------------------
    // readiness

    // WB may still own the oldest buffered entry, so count unclaimed ones
    assign a_present = ~head_uop.A_is_reg | A_reg_read_resp_valid | (a_reg_credit != '0);
    assign b_present = ~head_uop.B_is_reg | B_reg_read_resp_valid | (b_reg_credit != '0);

    assign oc.valid = head_valid & a_present & b_present;
    assign oc.uop = head_uop;
    assign head_fire = head_valid & a_present & b_present & oc.advance;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            a_reg_credit <= '0;
            b_reg_credit <= '0;
        end else begin
            a_reg_credit <= a_reg_credit + RR_CREDIT_W'(A_reg_read_resp_valid)
                - RR_CREDIT_W'(head_fire & head_uop.A_is_reg);
            b_reg_credit <= b_reg_credit + RR_CREDIT_W'(B_reg_read_resp_valid)
                - RR_CREDIT_W'(head_fire & head_uop.B_is_reg);
        end
    end

    // -------------------------------------------------------------------
    // register read data buffers

    q_fast_ready #(
        .payload_t  (word_t),
        .NUM_ENTRIES(PRF_RR_OUTPUT_BUFFER_SIZE)
    ) a_reg_buf (
        .CLK      (CLK),
        .nRST     (nRST),
        .enq_valid(A_reg_read_resp_valid),
        .enq_data (A_reg_read_resp_data),
        .enq_ready(),
        .deq_valid(a_reg_deq_valid),
        .deq_data (a_reg_deq_data),
        .deq_ready(oc.A_reg_pop)
    );

    q_fast_ready #(
        .payload_t  (word_t),
        .NUM_ENTRIES(PRF_RR_OUTPUT_BUFFER_SIZE)
    ) b_reg_buf (
        .CLK      (CLK),
        .nRST     (nRST),
        .enq_valid(B_reg_read_resp_valid),
        .enq_data (B_reg_read_resp_data),
        .enq_ready(),
        .deq_valid(b_reg_deq_valid),
        .deq_data (b_reg_deq_data),
        .deq_ready(oc.B_reg_pop)
    );

    // empty buffer bypasses to the response
    assign oc.A_reg_data = a_reg_deq_valid ? a_reg_deq_data : A_reg_read_resp_data;
    assign oc.B_reg_data = b_reg_deq_valid ? b_reg_deq_data : B_reg_read_resp_data;

    // -------------------------------------------------------------------
    // forward data buffers, captured one cycle after issue

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            a_fwd_enq <= 1'b0;
            b_fwd_enq <= 1'b0;
        end else begin
            a_fwd_enq <= issue_fire & issue_A_forward;
            b_fwd_enq <= issue_fire & issue_B_forward;
        end
    end

    always_ff @(posedge CLK) begin
        a_fwd_bank <= issue_A_bank;
        b_fwd_bank <= issue_B_bank;
    end

    q_fast_ready #(
        .payload_t  (word_t),
        .NUM_ENTRIES(PRF_RR_OUTPUT_BUFFER_SIZE)
    ) a_fwd_buf (
        .CLK      (CLK),
        .nRST     (nRST),
        .enq_valid(a_fwd_enq),
        .enq_data (forward_data_by_bank[a_fwd_bank]),
        .enq_ready(),
        .deq_valid(),
        .deq_data (oc.A_fwd_data),
        .deq_ready(oc.A_fwd_pop)
    );

    q_fast_ready #(
        .payload_t  (word_t),
        .NUM_ENTRIES(PRF_RR_OUTPUT_BUFFER_SIZE)
    ) b_fwd_buf (
        .CLK      (CLK),
        .nRST     (nRST),
        .enq_valid(b_fwd_enq),
        .enq_data (forward_data_by_bank[b_fwd_bank]),
        .enq_ready(),
        .deq_valid(),
        .deq_data (oc.B_fwd_data),
        .deq_ready(oc.B_fwd_pop)
    );

endmodule

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu (
    input  core_types_pkg::alu_op_t op,
    input  core_types_pkg::word_t   A,
    input  core_types_pkg::word_t   B,
    output core_types_pkg::word_t   out
);
    import core_types_pkg::*;

    logic [4:0] shamt;

    // shifts use the low five bits only
    assign shamt = B[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  out = A + B;
            ALU_SUB:  out = A - B;
            ALU_SLL:  out = A << shamt;
            ALU_SRL:  out = A >> shamt;
            ALU_SRA:  out = word_t'($signed(A) >>> shamt);
            ALU_SLT:  out = {31'b0, $signed(A) < $signed(B)};
            ALU_SLTU: out = {31'b0, A < B};
            ALU_XOR:  out = A ^ B;
            ALU_OR:   out = A | B;
            ALU_AND:  out = A & B;
            // unused encodings
            default:  out = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/oc_wb_if.sv
`default_nettype none

interface oc_wb_if;
    import core_types_pkg::*;

    // head of the collect stage
    logic     valid;
    alu_uop_t uop;
    word_t    A_reg_data;
    word_t    A_fwd_data;
    word_t    B_reg_data;
    word_t    B_fwd_data;

    // back from writeback
    logic     advance;
    logic     A_reg_pop;
    logic     A_fwd_pop;
    logic     B_reg_pop;
    logic     B_fwd_pop;

    modport collect (
        output valid, uop, A_reg_data, A_fwd_data, B_reg_data, B_fwd_data,
        input  advance, A_reg_pop, A_fwd_pop, B_reg_pop, B_fwd_pop
    );

    modport wb (
        input  valid, uop, A_reg_data, A_fwd_data, B_reg_data, B_fwd_data,
        output advance, A_reg_pop, A_fwd_pop, B_reg_pop, B_fwd_pop
    );

endinterface

`default_nettype wire

//--- rtl/q_fast_ready.sv
`default_nettype none

module q_fast_ready #(
    parameter type payload_t = logic [31:0],
    parameter int NUM_ENTRIES = 2
) (
    input  logic     CLK,
    input  logic     nRST,

    input  logic     enq_valid,
    input  payload_t enq_data,
    output logic     enq_ready,

    output logic     deq_valid,
    output payload_t deq_data,
    input  logic     deq_ready
);

    localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam int CNT_W = $clog2(NUM_ENTRIES + 1);

    payload_t mem [NUM_ENTRIES];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             enq_fire;
    logic             deq_fire;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(NUM_ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ready from fullness only
    assign enq_ready = (count != CNT_W'(NUM_ENTRIES));
    assign deq_valid = (count != '0);
    assign deq_data = mem[rd_ptr];

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (deq_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({enq_fire, deq_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    // -------------------------------------------------------------------
    // sizing

    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int LOG_PR_COUNT = 7;
    localparam int LOG_ROB_ENTRIES = 6;

    // queue and buffer depths
    localparam int IS_OC_BUFFER_SIZE = 2;
    localparam int PRF_RR_OUTPUT_BUFFER_SIZE = 3;

    // counts responses not yet claimed by a micro-op
    localparam int RR_CREDIT_W = $clog2(PRF_RR_OUTPUT_BUFFER_SIZE + 1);

    // -------------------------------------------------------------------
    // types

    typedef logic [31:0] word_t;
    typedef logic [LOG_PR_COUNT-1:0] pr_tag_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;

    // funct3 in the low bits, alternate encoding in bit 3
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    typedef struct packed {
        alu_op_t    op;
        logic       A_forward;
        logic       A_is_reg;
        logic       B_forward;
        logic       B_is_reg;
        pr_tag_t    dest_PR;
        rob_index_t ROB_index;
    } alu_uop_t;

endpackage

`default_nettype wire
